//--- rtl/coreTypes.sv
package coreTypes;

  // Field widths of the instruction and datapath
  parameter int regAddrBits = 5;
  parameter int dataBits = 32;
  parameter int immBits = 11;

  // Register forms in 6'h10..6'h17, bit 3 set for the immediate form
  typedef enum logic [5:0] {
    opAdd    = 6'h10,
    opSub    = 6'h11,
    opAnd    = 6'h12,
    opOr     = 6'h13,
    opXor    = 6'h14,
    opShl    = 6'h15,
    opLoad   = 6'h16,
    opStore  = 6'h17,
    opAddI   = 6'h18,
    opSubI   = 6'h19,
    opAndI   = 6'h1A,
    opOrI    = 6'h1B,
    opXorI   = 6'h1C,
    opShlI   = 6'h1D,
    opLoadI  = 6'h1E,
    opStoreI = 6'h1F
  } opcodeT;

  typedef enum logic [2:0] {
    aluAdd = 3'd0,
    aluSub = 3'd1,
    aluAnd = 3'd2,
    aluOr  = 3'd3,
    aluXor = 3'd4,
    aluShl = 3'd5
  } aluFuncT;

  // Operand sources, srcImm only for operand B
  typedef enum logic [1:0] {
    srcReg = 2'd0,
    srcFwd = 2'd1,
    srcRes = 2'd2,
    srcImm = 2'd3
  } srcSelT;

endpackage

//--- rtl/instrDecode.sv
`timescale 1ns/1ns

module instrDecode (
  input  logic                                gclk,
  input  logic                                reset,
  input  logic [coreTypes::dataBits-1:0]      instr,
  input  logic                                instrValid,
  output logic                                instrReady,
  output logic [coreTypes::regAddrBits-1:0]   rdAddrA,
  output logic [coreTypes::regAddrBits-1:0]   rdAddrB,
  output coreTypes::aluFuncT                  exFunc,
  output coreTypes::srcSelT                   exSelA,
  output coreTypes::srcSelT                   exSelB,
  output logic [coreTypes::dataBits-1:0]      exImm,
  output logic [coreTypes::regAddrBits-1:0]   exDest,
  output logic                                exWe,
  output logic                                exLoad,
  output logic                                exStore,
  input  logic [coreTypes::regAddrBits-1:0]   resDest,
  input  logic                                resWe
);

  logic [coreTypes::dataBits-1:0] dInst;  // Instruction register
  logic dValid;

  logic [5:0] dOpc;
  logic [coreTypes::regAddrBits-1:0] dRd, dRa, dRb;
  logic [coreTypes::immBits-1:0] dAlt;

  assign {dOpc, dRd, dRa, dRb, dAlt} = dInst;

  coreTypes::opcodeT dBase;  // Opcode folded onto its register form
  logic dKnown, dImm, dLoad, dStore, usesRb, stall;
  coreTypes::aluFuncT dFunc;
  coreTypes::srcSelT dSelA, dSelB;

  assign dBase  = coreTypes::opcodeT'({dOpc[5:4], 1'b0, dOpc[2:0]});
  assign dKnown = dValid && (dOpc[5:4] == 2'b01);  // Anything else is a no-op
  assign dImm   = dOpc[3];
  assign dLoad  = dKnown && (dBase == coreTypes::opLoad);
  assign dStore = dKnown && (dBase == coreTypes::opStore);
  assign usesRb = !dImm || dStore;  // Stores always read rb as data

  always_comb begin
    case (dBase)
      coreTypes::opSub: dFunc = coreTypes::aluSub;
      coreTypes::opAnd: dFunc = coreTypes::aluAnd;
      coreTypes::opOr:  dFunc = coreTypes::aluOr;
      coreTypes::opXor: dFunc = coreTypes::aluXor;
      coreTypes::opShl: dFunc = coreTypes::aluShl;
      default:          dFunc = coreTypes::aluAdd;  // Add, load and store address
    endcase
  end

  // Youngest writer wins
  function automatic coreTypes::srcSelT pickSrc(input logic [coreTypes::regAddrBits-1:0] r);
    logic nonZero;
    nonZero = (r != '0);
    if (nonZero && exWe && exDest == r)
      return coreTypes::srcFwd;
    else if (nonZero && resWe && resDest == r)
      return coreTypes::srcRes;
    else
      return coreTypes::srcReg;
  endfunction

  always_comb begin
    dSelA = pickSrc(dRa);
    dSelB = (dImm && !dStore) ? coreTypes::srcImm : pickSrc(dRb);
  end

  // Load in execute feeding this instruction
  assign stall = dKnown && exLoad && exWe && (exDest != '0) &&
                 ((exDest == dRa) || (usesRb && exDest == dRb));

  assign instrReady = !stall;
  assign rdAddrA = dRa;
  assign rdAddrB = dRb;

  always_ff @(posedge gclk) begin
    if (reset) begin
      dValid <= 1'b0;
    end else if (!stall) begin
      dValid <= instrValid;
      if (instrValid) dInst <= instr;
    end
  end

  // Execute control takes a bubble while stalled
  always_ff @(posedge gclk) begin
    if (reset) begin
      exWe    <= 1'b0;
      exLoad  <= 1'b0;
      exStore <= 1'b0;
    end else begin
      exWe    <= dKnown && !stall && !dStore && (dRd != '0);
      exLoad  <= dLoad && !stall;
      exStore <= dStore && !stall;
    end
  end

  always_ff @(posedge gclk) begin
    exFunc <= dFunc;
    exSelA <= dSelA;
    exSelB <= dSelB;
    exImm  <= {{(coreTypes::dataBits-coreTypes::immBits){dAlt[coreTypes::immBits-1]}}, dAlt};
    exDest <= dRd;
  end

endmodule

//--- rtl/regFile.sv
`timescale 1ns/1ns

module regFile (
  input  logic                                gclk,
  input  logic                                reset,
  input  logic [coreTypes::regAddrBits-1:0]   rdAddrA,
  input  logic [coreTypes::regAddrBits-1:0]   rdAddrB,
  output logic [coreTypes::dataBits-1:0]      rdDataA,
  output logic [coreTypes::dataBits-1:0]      rdDataB,
  input  logic                                wrEn,
  input  logic [coreTypes::regAddrBits-1:0]   wrAddr,
  input  logic [coreTypes::dataBits-1:0]      wrData
);

  localparam int numRegs = 1 << coreTypes::regAddrBits;

  logic [coreTypes::dataBits-1:0] regs [numRegs];

  always_ff @(posedge gclk) begin
    if (reset) begin
      for (int i = 0; i < numRegs; i++) regs[i] <= '0;
    end else if (wrEn && wrAddr != '0) begin
      regs[wrAddr] <= wrData;
    end
  end

  // Register 0 is hardwired
  assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
  assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

//--- rtl/aluExecute.sv
`timescale 1ns/1ns

module aluExecute (
  input  logic                                gclk,
  input  logic                                reset,
  input  coreTypes::aluFuncT                  exFunc,
  input  coreTypes::srcSelT                   exSelA,
  input  coreTypes::srcSelT                   exSelB,
  input  logic [coreTypes::dataBits-1:0]      exImm,
  input  logic                                exLoad,
  input  logic                                exStore,
  input  logic [coreTypes::regAddrBits-1:0]   exDest,
  input  logic                                exWe,
  input  logic [coreTypes::dataBits-1:0]      rdDataA,
  input  logic [coreTypes::dataBits-1:0]      rdDataB,
  input  logic [coreTypes::dataBits-1:0]      resValue,
  output logic [coreTypes::dataBits-1:0]      exResult,
  output logic [coreTypes::dataBits-1:0]      memAddr,
  output logic [coreTypes::dataBits-1:0]      storeData,
  output logic                                memWrite,
  output logic                                resLoadNext,
  output logic [coreTypes::regAddrBits-1:0]   resDestNext,
  output logic                                resWeNext
);

  logic [coreTypes::dataBits-1:0] opRegA, opRegB;  // Register file values from decode
  logic [coreTypes::dataBits-1:0] resHold;         // Result value seen during decode
  logic [coreTypes::dataBits-1:0] opA, rbData, opB, aluOut;

  always_ff @(posedge gclk) begin
    opRegA  <= rdDataA;
    opRegB  <= rdDataB;
    resHold <= resValue;
  end

  always_comb begin
    case (exSelA)
      coreTypes::srcFwd: opA = exResult;
      coreTypes::srcRes: opA = resHold;
      default:           opA = opRegA;
    endcase
  end

  // rb with forwarding applied, also the store data
  always_comb begin
    case (exSelB)
      coreTypes::srcFwd: rbData = exResult;
      coreTypes::srcRes: rbData = resHold;
      coreTypes::srcImm: rbData = exImm;
      default:           rbData = opRegB;
    endcase
  end

  assign opB = exStore ? exImm : rbData;  // Store address is ra plus immediate

  always_comb begin
    case (exFunc)
      coreTypes::aluSub: aluOut = opA - opB;
      coreTypes::aluAnd: aluOut = opA & opB;
      coreTypes::aluOr:  aluOut = opA | opB;
      coreTypes::aluXor: aluOut = opA ^ opB;
      coreTypes::aluShl: aluOut = opA << opB[4:0];
      default:           aluOut = opA + opB;
    endcase
  end

  always_ff @(posedge gclk) begin
    if (reset) exResult <= '0;
    else       exResult <= aluOut;
  end

  // Memory sees the address during the execute cycle
  assign memAddr   = aluOut;
  assign storeData = rbData;
  assign memWrite  = exStore;

  assign resLoadNext = exLoad;
  assign resDestNext = exDest;
  assign resWeNext   = exWe;

endmodule

//--- rtl/resultStage.sv
`timescale 1ns/1ns

module resultStage #(
  parameter int memAddrBits = 8
) (
  input  logic                                gclk,
  input  logic                                reset,
  input  logic [coreTypes::dataBits-1:0]      memAddr,
  input  logic [coreTypes::dataBits-1:0]      storeData,
  input  logic                                memWrite,
  input  logic                                resLoadNext,
  input  logic [coreTypes::regAddrBits-1:0]   resDestNext,
  input  logic                                resWeNext,
  input  logic [coreTypes::dataBits-1:0]      exResult,
  output logic [coreTypes::dataBits-1:0]      resValue,
  output logic                                wbValid,
  output logic [coreTypes::regAddrBits-1:0]   wbReg,
  output logic [coreTypes::dataBits-1:0]      wbData,
  output logic [coreTypes::regAddrBits-1:0]   resDest,
  output logic                                resWe
);

  localparam int memWords = 1 << memAddrBits;

  logic [coreTypes::dataBits-1:0] mem [memWords];
  logic [coreTypes::dataBits-1:0] loadData;
  logic [memAddrBits-1:0] wordIdx;
  logic resLoad;

  initial begin
    for (int i = 0; i < memWords; i++) mem[i] = '0;
  end

  assign wordIdx = memAddr[memAddrBits-1:0];  // Upper bits ignored

  always_ff @(posedge gclk) begin
    if (memWrite) mem[wordIdx] <= storeData;
    loadData <= mem[wordIdx];
  end

  always_ff @(posedge gclk) begin
    if (reset) begin
      resWe <= 1'b0;
    end else begin
      resWe <= resWeNext;
    end
  end

  always_ff @(posedge gclk) begin
    resLoad <= resLoadNext;
    resDest <= resDestNext;
  end

  assign resValue = resLoad ? loadData : exResult;

  // Write-back straight from the result registers
  assign wbValid = resWe;
  assign wbReg   = resDest;
  assign wbData  = resValue;

endmodule

//--- rtl/pipeCore.sv
`timescale 1ns/1ns

module pipeCore #(
  parameter int memAddrBits = 8
) (
  input  logic                                gclk,
  input  logic                                reset,
  input  logic [coreTypes::dataBits-1:0]      instr,
  input  logic                                instrValid,
  output logic                                instrReady,
  output logic                                wbValid,
  output logic [coreTypes::regAddrBits-1:0]   wbReg,
  output logic [coreTypes::dataBits-1:0]      wbData
);

  logic [coreTypes::regAddrBits-1:0] rdAddrA, rdAddrB, exDest, resDest, resDestNext;
  logic [coreTypes::dataBits-1:0] rdDataA, rdDataB, exImm, exResult, resValue;
  logic [coreTypes::dataBits-1:0] memAddr, storeData;
  coreTypes::aluFuncT exFunc;
  coreTypes::srcSelT exSelA, exSelB;
  logic exWe, exLoad, exStore, resWe, memWrite, resLoadNext, resWeNext;

  instrDecode uDecode (
    .gclk(gclk), .reset(reset),
    .instr(instr), .instrValid(instrValid), .instrReady(instrReady),
    .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
    .exFunc(exFunc), .exSelA(exSelA), .exSelB(exSelB), .exImm(exImm),
    .exDest(exDest), .exWe(exWe), .exLoad(exLoad), .exStore(exStore),
    .resDest(resDest), .resWe(resWe)
  );

  // Write port fed by the write-back signals
  regFile uRegs (
    .gclk(gclk), .reset(reset),
    .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
    .rdDataA(rdDataA), .rdDataB(rdDataB),
    .wrEn(wbValid), .wrAddr(wbReg), .wrData(wbData)
  );

  aluExecute uExec (
    .gclk(gclk), .reset(reset),
    .exFunc(exFunc), .exSelA(exSelA), .exSelB(exSelB), .exImm(exImm),
    .exLoad(exLoad), .exStore(exStore), .exDest(exDest), .exWe(exWe),
    .rdDataA(rdDataA), .rdDataB(rdDataB), .resValue(resValue),
    .exResult(exResult), .memAddr(memAddr), .storeData(storeData),
    .memWrite(memWrite), .resLoadNext(resLoadNext),
    .resDestNext(resDestNext), .resWeNext(resWeNext)
  );

  resultStage #(.memAddrBits(memAddrBits)) uResult (
    .gclk(gclk), .reset(reset),
    .memAddr(memAddr), .storeData(storeData), .memWrite(memWrite),
    .resLoadNext(resLoadNext), .resDestNext(resDestNext), .resWeNext(resWeNext),
    .exResult(exResult), .resValue(resValue),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
    .resDest(resDest), .resWe(resWe)
  );

endmodule

//--- testbench/pipeCoreTb.sv
`timescale 1ns/1ns

module pipeCoreTb;

  localparam int memAddrBits = 8;

  logic gclk, reset, instrValid, instrReady, wbValid;
  logic [31:0] instr, wbData;
  logic [4:0] wbReg;

  // Program-order model of the slice
  logic [31:0] modelRegs [32];
  logic [31:0] modelMem [1 << memAddrBits];
  logic [4:0] expRegQ [$];
  logic [31:0] expDataQ [$];
  int expEdgeQ [$];    // Edge where each write-back is sampled
  int stallEdgeQ [$];  // Edges where instrReady reads low
  int wbIdx = 0;
  int stallIdx = 0;
  int edgeCount = 0;
  logic monitorOn = 1'b0;
  string testName = "reset";
  logic [15:0] lfsrState = 16'd34678;
  logic prevLoad = 1'b0;  // Last accepted instruction is a load with rd not 0
  logic [4:0] prevRd = '0;
  int prevExecEdge = 0;

  pipeCore #(.memAddrBits(memAddrBits)) DUT (
    .gclk(gclk), .reset(reset), .instr(instr), .instrValid(instrValid),
    .instrReady(instrReady), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
  );

  initial begin
    gclk = 1'b0;
    forever #4 gclk = ~gclk;
  end

  task automatic reportFailure(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic reportMismatch(input string what, input logic [31:0] expVal,
                                input logic [31:0] actVal);
    reportFailure($sformatf("error %s %s: expected %0h actual %0h",
                            testName, what, expVal, actVal));
  endtask

  // Galois LFSR, taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [31:0] drawBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsrState[0]};
      lfsrState = lfsrStep(lfsrState);
    end
    return v;
  endfunction

  // Applies one instruction at its accept edge
  task automatic modelAccept(input logic [31:0] word, input int acceptEdge);
    logic [5:0] op, base;
    logic [4:0] rd, ra, rb;
    logic [10:0] imm;
    logic known, isLoad, isStore, readsRb, stalled;
    logic [31:0] a, b, sum, result;
    int execEdge;
    {op, rd, ra, rb, imm} = word;
    base = {op[5:4], 1'b0, op[2:0]};  // Bit 3 only picks the immediate form
    known = (op[5:4] == 2'b01);
    isLoad = known && (base == coreTypes::opLoad);
    isStore = known && (base == coreTypes::opStore);
    readsRb = !op[3] || isStore;
    stalled = known && prevLoad && (prevExecEdge == acceptEdge) &&
              ((prevRd == ra) || (readsRb && prevRd == rb));
    execEdge = stalled ? acceptEdge + 2 : acceptEdge + 1;
    if (stalled) stallEdgeQ.push_back(acceptEdge + 1);
    a = modelRegs[ra];
    b = (op[3] || isStore) ? {{21{imm[10]}}, imm} : modelRegs[rb];
    sum = a + b;
    case (base)
      coreTypes::opSub:  result = a - b;
      coreTypes::opAnd:  result = a & b;
      coreTypes::opOr:   result = a | b;
      coreTypes::opXor:  result = a ^ b;
      coreTypes::opShl:  result = a << b[4:0];
      coreTypes::opLoad: result = modelMem[sum[memAddrBits-1:0]];
      default:           result = sum;
    endcase
    if (isStore) modelMem[sum[memAddrBits-1:0]] = modelRegs[rb];
    if (known && !isStore && rd != '0) begin
      modelRegs[rd] = result;
      expRegQ.push_back(rd);
      expDataQ.push_back(result);
      expEdgeQ.push_back(execEdge + 2);
    end
    prevLoad = isLoad && (rd != '0);
    prevRd = rd;
    prevExecEdge = execEdge;
  endtask

  task automatic issue(input logic [5:0] op, input logic [4:0] rd, input logic [4:0] ra,
                       input logic [4:0] rb, input logic [10:0] imm);
    int waitCycles;
    instr <= {op, rd, ra, rb, imm};
    instrValid <= 1'b1;
    waitCycles = 0;
    @(posedge gclk);
    while (!instrReady) begin
      waitCycles++;
      if (waitCycles > 10) reportFailure("instruction never accepted, instrReady stuck low");
      @(posedge gclk);
    end
    modelAccept({op, rd, ra, rb, imm}, edgeCount);
  endtask

  task automatic drain();
    int waitCycles;
    instrValid <= 1'b0;
    waitCycles = 0;
    while (wbIdx < expEdgeQ.size() || stallIdx < stallEdgeQ.size()) begin
      waitCycles++;
      if (waitCycles > 20) reportFailure("expected write-backs never arrived");
      @(posedge gclk);
    end
  endtask

  task automatic checkIdle();
    assert (instrReady === 1'b1) else reportMismatch("instrReady", 32'd1, 32'(instrReady));
    assert (wbValid === 1'b0) else reportMismatch("wbValid", 32'd0, 32'(wbValid));
  endtask

  // Write-back, latency and stall checks at every edge
  always @(posedge gclk) begin
    logic expectPulse, expectReady;
    edgeCount <= edgeCount + 1;
    if (monitorOn) begin
      expectReady = !(stallIdx < stallEdgeQ.size() && stallEdgeQ[stallIdx] == edgeCount);
      if (!expectReady) stallIdx++;
      assert (instrReady === expectReady)
        else reportMismatch("instrReady", 32'(expectReady), 32'(instrReady));
      expectPulse = (wbIdx < expEdgeQ.size() && expEdgeQ[wbIdx] == edgeCount);
      assert (wbValid === expectPulse)
        else reportMismatch("wbValid", 32'(expectPulse), 32'(wbValid));
      if (expectPulse) begin
        assert (wbReg === expRegQ[wbIdx])
          else reportMismatch("wbReg", 32'(expRegQ[wbIdx]), 32'(wbReg));
        assert (wbData === expDataQ[wbIdx])
          else reportMismatch("wbData", expDataQ[wbIdx], wbData);
        wbIdx++;
      end
    end
  end

  initial begin
    logic [5:0] op;
    logic [31:0] pick;
    instr <= '0;
    instrValid <= 1'b0;
    reset <= 1'b1;
    for (int i = 0; i < 32; i++) modelRegs[i] = '0;
    for (int i = 0; i < (1 << memAddrBits); i++) modelMem[i] = '0;
    @(posedge gclk);
    repeat (4) begin
      @(posedge gclk);
      checkIdle();
    end
    reset <= 1'b0;
    repeat (2) begin  // Last reset cycle and the first one after it
      @(posedge gclk);
      checkIdle();
    end
    monitorOn = 1'b1;

    testName = "random alu";
    for (int r = 1; r < 8; r++) issue(coreTypes::opAddI, 5'(r), 5'd0, 5'd0, 11'(drawBits(11)));
    for (int n = 0; n < 200; n++) begin
      pick = drawBits(3) % 32'd6;
      op = {2'b01, drawBits(1) == 32'd1, pick[2:0]};
      issue(op, 5'(drawBits(3)), 5'(drawBits(3)), 5'(drawBits(3)), 11'(drawBits(11)));
    end
    drain();

    testName = "store load";
    issue(coreTypes::opAddI, 5'd9, 5'd0, 5'd0, 11'h155);
    issue(coreTypes::opShlI, 5'd9, 5'd9, 5'd0, 11'd12);
    issue(coreTypes::opAddI, 5'd10, 5'd0, 5'd0, 11'd40);   // Base address
    issue(coreTypes::opStore, 5'd0, 5'd10, 5'd9, 11'd3);
    issue(coreTypes::opLoadI, 5'd11, 5'd10, 5'd0, 11'd3);
    issue(coreTypes::opAddI, 5'd12, 5'd0, 5'd0, 11'd3);
    issue(coreTypes::opLoad, 5'd13, 5'd10, 5'd12, 11'd0);  // Address ra plus rb
    issue(coreTypes::opLoadI, 5'd14, 5'd0, 5'd0, 11'h0F0); // Never written
    drain();

    testName = "load use";
    issue(coreTypes::opLoadI, 5'd15, 5'd10, 5'd0, 11'd3);
    issue(coreTypes::opAdd, 5'd16, 5'd15, 5'd9, 11'd0);
    issue(coreTypes::opLoadI, 5'd17, 5'd10, 5'd0, 11'd3);
    issue(coreTypes::opStore, 5'd0, 5'd10, 5'd17, 11'd8);  // Loaded value as store data
    issue(coreTypes::opLoadI, 5'd18, 5'd10, 5'd0, 11'd8);
    issue(coreTypes::opXorI, 5'd19, 5'd18, 5'd0, 11'h2AA);
    drain();

    testName = "zero and no-op";
    issue(coreTypes::opAddI, 5'd0, 5'd0, 5'd0, 11'h123);
    issue(coreTypes::opAdd, 5'd20, 5'd0, 5'd0, 11'd0);
    issue(6'h00, 5'd21, 5'd9, 5'd9, 11'd1);
    issue(6'h3F, 5'd22, 5'd9, 5'd9, 11'd1);
    issue(6'h27, 5'd23, 5'd9, 5'd9, 11'd1);
    issue(coreTypes::opStoreI, 5'd24, 5'd10, 5'd9, 11'd20);
    issue(coreTypes::opOrI, 5'd25, 5'd21, 5'd0, 11'h400);  // r21 untouched by the no-op
    drain();

    testName = "random mixed";
    for (int n = 0; n < 150; n++) begin
      pick = drawBits(3);
      op = {2'b01, drawBits(1) == 32'd1, pick[2:0]};
      issue(op, 5'(drawBits(3)), 5'(drawBits(3)), 5'(drawBits(3)), 11'(drawBits(11)));
    end
    drain();
    repeat (3) @(posedge gclk);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- pipeCore.f
rtl/coreTypes.sv
rtl/instrDecode.sv
rtl/regFile.sv
rtl/aluExecute.sv
rtl/resultStage.sv
rtl/pipeCore.sv
testbench/pipeCoreTb.sv

//--- runSim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
  --top-module pipeCoreTb -Mdir obj_dir -o pipeCoreSim -f pipeCore.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/pipeCoreSim > sim.log 2>&1
runStatus=$?
cat sim.log
if [ $runStatus -ne 0 ]; then
  echo "Simulation exited with status $runStatus"
  exit 1
fi

if grep -qx "ALL CHECKS PASSED" sim.log; then
  echo "Result: pass"
  exit 0
fi
echo "Result: fail"
exit 1
